//--- demosaic_pkg.sv
package demosaic_pkg;

	// ----------------------------------------
	// image geometry and widths
	// ----------------------------------------
	localparam int coord_bits = 7;
	localparam int img_dim = 128;
	localparam int pix_bits = 8;
	localparam int addr_bits = 2 * coord_bits;
	localparam int num_chan = 3;

	// per-pixel schedule, steps 0..8 read, step 9 computes
	localparam int num_neighbors = 9;
	localparam int step_bits = 4;
	localparam int calc_step = 9;
	localparam int drain_cycles = 12;
	localparam int drain_bits = $clog2(drain_cycles);

	// neighbour slots in the cache
	localparam int nb_up = 0;
	localparam int nb_right = 1;
	localparam int nb_down = 2;
	localparam int nb_left = 3;
	localparam int nb_ul = 4;
	localparam int nb_ur = 5;
	localparam int nb_dr = 6;
	localparam int nb_dl = 7;
	localparam int nb_center = 8;

	// offsets per slot
	localparam int nb_dy [num_neighbors] = '{-1, 0, 1, 0, -1, -1, 1, 1, 0};
	localparam int nb_dx [num_neighbors] = '{0, 1, 0, -1, -1, 1, 1, -1, 0};

	typedef struct packed {
		logic [coord_bits-1:0] y;
		logic [coord_bits-1:0] x;
	} pix_coord_t;

	typedef struct packed {
		logic [pix_bits-1:0] g;
		logic [pix_bits-1:0] r;
		logic [pix_bits-1:0] b;
	} rgb_t;

	typedef struct packed {
		logic g;
		logic r;
		logic b;
	} chan_req_t;

	typedef enum logic [1:0] {
		ph_fill = 2'd0,
		ph_bilinear = 2'd1,
		ph_drain = 2'd2
	} demosaic_phase_t;

	// encoding is {row parity, column parity}
	typedef enum logic [1:0] {
		site_gr = 2'b00,
		site_r = 2'b01,
		site_b = 2'b10,
		site_gb = 2'b11
	} bayer_site_t;

	function automatic bayer_site_t site_of(input pix_coord_t p);
		return bayer_site_t'({p.y[0], p.x[0]});
	endfunction

endpackage

//--- demosaic_ctrl.sv
`timescale 1ns/100ps

module demosaic_ctrl (
	input logic clk,
	input logic reset,
	input logic in_en_i,
	output demosaic_pkg::demosaic_phase_t phase_o,
	output demosaic_pkg::pix_coord_t scan_pos_o,
	output logic [demosaic_pkg::step_bits-1:0] step_o,
	output logic calc_en_o,
	output logic done_o
);
	import demosaic_pkg::*;

	demosaic_phase_t phase_q;
	logic [addr_bits-1:0] pos_q;
	logic [step_bits-1:0] step_q;
	logic [drain_bits-1:0] drain_q;
	logic last_pos;
	logic last_step;

	assign last_pos = &pos_q;
	assign last_step = (step_q == step_bits'(calc_step));

	// ----------------------------------------
	// phase, raster position, step counter
	// ----------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase_q <= ph_fill;
			pos_q <= '0;
			step_q <= '0;
			drain_q <= '0;
			done_o <= 1'b0;
		end else begin
			case (phase_q)
				ph_fill: begin
					// one raw sample per accepted cycle
					if (in_en_i) begin
						pos_q <= pos_q + 1'b1;
						if (last_pos) begin
							phase_q <= ph_bilinear;
						end
					end
				end
				ph_bilinear: begin
					if (last_step) begin
						step_q <= '0;
						pos_q <= pos_q + 1'b1;
						if (last_pos) begin
							phase_q <= ph_drain;
						end
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				ph_drain: begin
					// let the last write leave the arbiter
					if (!done_o) begin
						if (drain_q == drain_bits'(drain_cycles - 1)) begin
							done_o <= 1'b1;
						end else begin
							drain_q <= drain_q + 1'b1;
						end
					end
				end
				default: begin
					phase_q <= ph_fill;
				end
			endcase
		end
	end

	assign phase_o = phase_q;
	assign scan_pos_o = pix_coord_t'(pos_q);
	assign step_o = step_q;
	assign calc_en_o = (phase_q == ph_bilinear) && last_step;

endmodule

//--- neighbor_fetch.sv
`timescale 1ns/100ps

module neighbor_fetch (
	input logic clk,
	input demosaic_pkg::demosaic_phase_t phase_i,
	input demosaic_pkg::pix_coord_t scan_pos_i,
	input logic [demosaic_pkg::step_bits-1:0] step_i,
	input demosaic_pkg::rgb_t rdata_i,
	output demosaic_pkg::chan_req_t rd_req_o,
	output demosaic_pkg::pix_coord_t rd_addr_o,
	output demosaic_pkg::rgb_t cache_o [demosaic_pkg::num_neighbors]
);
	import demosaic_pkg::*;

	logic fetch_en;
	int nb_idx;
	pix_coord_t nb_pos;
	bayer_site_t nb_site;
	rgb_t cache_q [num_neighbors];

	// -1 reads 1, img_dim reads img_dim-2
	function automatic logic [coord_bits-1:0] mirror(input int c);
		logic [coord_bits-1:0] m;
		if (c < 0) begin
			m = coord_bits'(1);
		end else if (c > img_dim - 1) begin
			m = coord_bits'(img_dim - 2);
		end else begin
			m = coord_bits'(c);
		end
		return m;
	endfunction

	// ----------------------------------------
	// address and channel requests
	// ----------------------------------------
	always_comb begin
		fetch_en = (phase_i == ph_bilinear) && (step_i < num_neighbors);
		// compute step reuses the centre slot, nothing is requested there
		nb_idx = (step_i < num_neighbors) ? int'(step_i) : nb_center;
		nb_pos.y = mirror(int'(scan_pos_i.y) + nb_dy[nb_idx]);
		nb_pos.x = mirror(int'(scan_pos_i.x) + nb_dx[nb_idx]);
		nb_site = site_of(nb_pos);
	end

	// only the colour the sensor really sampled there
	assign rd_req_o.g = fetch_en && (nb_site == site_gr || nb_site == site_gb);
	assign rd_req_o.r = fetch_en && (nb_site == site_r);
	assign rd_req_o.b = fetch_en && (nb_site == site_b);
	assign rd_addr_o = nb_pos;

	// neighbour cache, one slot per step
	always_ff @(posedge clk) begin
		if (rd_req_o.g) begin
			cache_q[nb_idx].g <= rdata_i.g;
		end
		if (rd_req_o.r) begin
			cache_q[nb_idx].r <= rdata_i.r;
		end
		if (rd_req_o.b) begin
			cache_q[nb_idx].b <= rdata_i.b;
		end
	end

	assign cache_o = cache_q;

	// step counter must wrap after the compute step
	step_range_a: assert property (@(posedge clk) step_i <= step_bits'(calc_step))
		else $error("neighbour step out of range");

endmodule

//--- bilinear_interp.sv
`timescale 1ns/100ps

module bilinear_interp (
	input logic clk,
	input logic reset,
	input logic calc_en_i,
	input demosaic_pkg::pix_coord_t scan_pos_i,
	input demosaic_pkg::rgb_t cache_i [demosaic_pkg::num_neighbors],
	output logic wr_strobe_o,
	output demosaic_pkg::pix_coord_t wr_pos_o,
	output demosaic_pkg::rgb_t wr_pixel_o
);
	import demosaic_pkg::*;

	rgb_t calc_pixel;

	// rounded means
	function automatic logic [pix_bits-1:0] avg2(input logic [pix_bits-1:0] a,
			input logic [pix_bits-1:0] b);
		logic [pix_bits:0] s;
		s = {1'b0, a} + {1'b0, b} + 1'b1;
		return s[pix_bits:1];
	endfunction

	function automatic logic [pix_bits-1:0] avg4(input logic [pix_bits-1:0] a,
			input logic [pix_bits-1:0] b, input logic [pix_bits-1:0] c,
			input logic [pix_bits-1:0] d);
		logic [pix_bits+1:0] s;
		s = {2'b00, a} + {2'b00, b} + {2'b00, c} + {2'b00, d} + 2'd2;
		return s[pix_bits+1:2];
	endfunction

	always_comb begin
		calc_pixel = cache_i[nb_center];
		case (site_of(scan_pos_i))
			site_gr: begin
				calc_pixel.r = avg2(cache_i[nb_left].r, cache_i[nb_right].r);
				calc_pixel.b = avg2(cache_i[nb_up].b, cache_i[nb_down].b);
			end
			site_gb: begin
				calc_pixel.r = avg2(cache_i[nb_up].r, cache_i[nb_down].r);
				calc_pixel.b = avg2(cache_i[nb_left].b, cache_i[nb_right].b);
			end
			site_r: begin
				calc_pixel.g = avg4(cache_i[nb_up].g, cache_i[nb_right].g,
					cache_i[nb_down].g, cache_i[nb_left].g);
				calc_pixel.b = avg4(cache_i[nb_ul].b, cache_i[nb_ur].b,
					cache_i[nb_dr].b, cache_i[nb_dl].b);
			end
			site_b: begin
				calc_pixel.g = avg4(cache_i[nb_up].g, cache_i[nb_right].g,
					cache_i[nb_down].g, cache_i[nb_left].g);
				calc_pixel.r = avg4(cache_i[nb_ul].r, cache_i[nb_ur].r,
					cache_i[nb_dr].r, cache_i[nb_dl].r);
			end
			default: begin
				calc_pixel = cache_i[nb_center];
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_strobe_o <= 1'b0;
		end else begin
			wr_strobe_o <= calc_en_i;
		end
	end

	always_ff @(posedge clk) begin
		if (calc_en_i) begin
			wr_pos_o <= scan_pos_i;
			wr_pixel_o <= calc_pixel;
		end
	end

endmodule

//--- mem_port_arb.sv
`timescale 1ns/100ps

module mem_port_arb (
	input logic clk,
	input logic reset,
	input demosaic_pkg::demosaic_phase_t phase_i,
	input logic in_en_i,
	input logic [demosaic_pkg::pix_bits-1:0] data_in_i,
	input demosaic_pkg::pix_coord_t scan_pos_i,
	input logic wr_strobe_i,
	input demosaic_pkg::pix_coord_t wr_pos_i,
	input demosaic_pkg::rgb_t wr_pixel_i,
	input demosaic_pkg::chan_req_t rd_req_i,
	input demosaic_pkg::pix_coord_t rd_addr_i,
	output demosaic_pkg::chan_req_t wr_o,
	output demosaic_pkg::pix_coord_t addr_o [demosaic_pkg::num_chan],
	output demosaic_pkg::rgb_t wdata_o
);
	import demosaic_pkg::*;

	// channel index 0 green, 1 red, 2 blue
	logic fill_wr;
	logic new_wr;
	pix_coord_t new_pos;
	logic [pix_bits-1:0] new_data [num_chan];
	logic [num_chan-1:0] rd_v;
	logic [num_chan-1:0] wr_v;
	logic [pix_bits-1:0] wd_v [num_chan];

	assign fill_wr = (phase_i == ph_fill) && in_en_i;
	assign new_wr = fill_wr || wr_strobe_i;
	assign new_pos = fill_wr ? scan_pos_i : wr_pos_i;
	assign new_data[0] = fill_wr ? data_in_i : wr_pixel_i.g;
	assign new_data[1] = fill_wr ? data_in_i : wr_pixel_i.r;
	assign new_data[2] = fill_wr ? data_in_i : wr_pixel_i.b;
	assign rd_v = {rd_req_i.b, rd_req_i.r, rd_req_i.g};

	for (genvar c = 0; c < num_chan; c++) begin : g_chan
		logic hold_valid;
		pix_coord_t hold_pos;
		logic [pix_bits-1:0] hold_data;

		// reads win, a blocked write waits here
		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				hold_valid <= 1'b0;
			end else if (new_wr && rd_v[c]) begin
				hold_valid <= 1'b1;
			end else if (hold_valid && !rd_v[c]) begin
				hold_valid <= 1'b0;
			end
		end

		always_ff @(posedge clk) begin
			if (new_wr && rd_v[c]) begin
				hold_pos <= new_pos;
				hold_data <= new_data[c];
			end
		end

		assign wr_v[c] = !rd_v[c] && (new_wr || hold_valid);
		assign wd_v[c] = hold_valid ? hold_data : new_data[c];
		assign addr_o[c] = rd_v[c] ? rd_addr_i : (hold_valid ? hold_pos : new_pos);

		// pending write must drain within the read steps of the next pixel
		hold_free_a: assert property (@(posedge clk) disable iff (reset)
			new_wr |-> !hold_valid)
			else $error("write arrived while channel %0d still held one", c);
	end

	assign wr_o = '{g: wr_v[0], r: wr_v[1], b: wr_v[2]};
	assign wdata_o = '{g: wd_v[0], r: wd_v[1], b: wd_v[2]};

endmodule

//--- demosaic_top.sv
`timescale 1ns/100ps

module demosaic_top (
	input logic clk,
	input logic reset,
	input logic in_en_i,
	input logic [demosaic_pkg::pix_bits-1:0] data_in_i,
	output logic wr_g_o,
	output logic wr_r_o,
	output logic wr_b_o,
	output logic [demosaic_pkg::addr_bits-1:0] addr_g_o,
	output logic [demosaic_pkg::addr_bits-1:0] addr_r_o,
	output logic [demosaic_pkg::addr_bits-1:0] addr_b_o,
	output logic [demosaic_pkg::pix_bits-1:0] wdata_g_o,
	output logic [demosaic_pkg::pix_bits-1:0] wdata_r_o,
	output logic [demosaic_pkg::pix_bits-1:0] wdata_b_o,
	input logic [demosaic_pkg::pix_bits-1:0] rdata_g_i,
	input logic [demosaic_pkg::pix_bits-1:0] rdata_r_i,
	input logic [demosaic_pkg::pix_bits-1:0] rdata_b_i,
	output logic done_o
);
	import demosaic_pkg::*;

	demosaic_phase_t phase;
	pix_coord_t scan_pos;
	logic [step_bits-1:0] step;
	logic calc_en;
	chan_req_t rd_req;
	pix_coord_t rd_addr;
	rgb_t rdata;
	rgb_t cache [num_neighbors];
	logic wr_strobe;
	pix_coord_t wr_pos;
	rgb_t wr_pixel;
	chan_req_t wr_chan;
	pix_coord_t addr [num_chan];
	rgb_t wdata;

	assign rdata = '{g: rdata_g_i, r: rdata_r_i, b: rdata_b_i};

	demosaic_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.in_en_i(in_en_i),
		.phase_o(phase),
		.scan_pos_o(scan_pos),
		.step_o(step),
		.calc_en_o(calc_en),
		.done_o(done_o)
	);

	neighbor_fetch u_fetch (
		.clk(clk),
		.phase_i(phase),
		.scan_pos_i(scan_pos),
		.step_i(step),
		.rdata_i(rdata),
		.rd_req_o(rd_req),
		.rd_addr_o(rd_addr),
		.cache_o(cache)
	);

	bilinear_interp u_interp (
		.clk(clk),
		.reset(reset),
		.calc_en_i(calc_en),
		.scan_pos_i(scan_pos),
		.cache_i(cache),
		.wr_strobe_o(wr_strobe),
		.wr_pos_o(wr_pos),
		.wr_pixel_o(wr_pixel)
	);

	mem_port_arb u_arb (
		.clk(clk),
		.reset(reset),
		.phase_i(phase),
		.in_en_i(in_en_i),
		.data_in_i(data_in_i),
		.scan_pos_i(scan_pos),
		.wr_strobe_i(wr_strobe),
		.wr_pos_i(wr_pos),
		.wr_pixel_i(wr_pixel),
		.rd_req_i(rd_req),
		.rd_addr_i(rd_addr),
		.wr_o(wr_chan),
		.addr_o(addr),
		.wdata_o(wdata)
	);

	// memory ports
	assign wr_g_o = wr_chan.g;
	assign wr_r_o = wr_chan.r;
	assign wr_b_o = wr_chan.b;
	assign addr_g_o = addr[0];
	assign addr_r_o = addr[1];
	assign addr_b_o = addr[2];
	assign wdata_g_o = wdata.g;
	assign wdata_r_o = wdata.r;
	assign wdata_b_o = wdata.b;

endmodule

//--- tb_demosaic_model.svh
`ifndef TB_DEMOSAIC_MODEL_SVH
`define TB_DEMOSAIC_MODEL_SVH

// colour the sensor sampled at a site, 0 green, 1 red, 2 blue
function automatic int sampled_chan(input int y, input int x);
	if ((y % 2) == (x % 2)) begin
		return 0;
	end else if ((y % 2) == 0) begin
		return 1;
	end
	return 2;
endfunction

// reflect about the border pixel, so -1 gives 1 and img_dim gives img_dim-2
function automatic int mirror_coord(input int c);
	if (c < 0) begin
		return -c;
	end else if (c > img_dim - 1) begin
		return 2 * (img_dim - 1) - c;
	end
	return c;
endfunction

// missing colours are the rounded mean of the 3x3 window samples of that colour
function automatic rgb_t expected_rgb(input int y, input int x);
	int chan_sum [3];
	int chan_cnt [3];
	logic [pix_bits-1:0] val [3];
	int own;
	int ny;
	int nx;
	int c;
	rgb_t res;
	own = sampled_chan(y, x);
	for (int k = 0; k < 3; k++) begin
		chan_sum[k] = 0;
		chan_cnt[k] = 0;
	end
	for (int dy = -1; dy <= 1; dy++) begin
		for (int dx = -1; dx <= 1; dx++) begin
			if (dy != 0 || dx != 0) begin
				ny = mirror_coord(y + dy);
				nx = mirror_coord(x + dx);
				c = sampled_chan(ny, nx);
				chan_sum[c] += int'(raw_img[ny * img_dim + nx]);
				chan_cnt[c] += 1;
			end
		end
	end
	for (int k = 0; k < 3; k++) begin
		if (k == own) begin
			val[k] = raw_img[y * img_dim + x];
		end else begin
			val[k] = pix_bits'((chan_sum[k] + chan_cnt[k] / 2) / chan_cnt[k]);
		end
	end
	res.g = val[0];
	res.r = val[1];
	res.b = val[2];
	return res;
endfunction

`endif

//--- tb_demosaic_top.sv
`timescale 1ns/100ps

module tb_demosaic_top;
	import demosaic_pkg::*;

	localparam int num_pix = img_dim * img_dim;
	localparam int fill_timeout = 2 * num_pix;
	localparam int done_timeout = 11 * num_pix;

	logic clk;
	logic reset;
	logic in_en;
	logic [pix_bits-1:0] data_in;
	logic wr_g;
	logic wr_r;
	logic wr_b;
	logic [addr_bits-1:0] addr_g;
	logic [addr_bits-1:0] addr_r;
	logic [addr_bits-1:0] addr_b;
	logic [pix_bits-1:0] wdata_g;
	logic [pix_bits-1:0] wdata_r;
	logic [pix_bits-1:0] wdata_b;
	logic [pix_bits-1:0] rdata_g;
	logic [pix_bits-1:0] rdata_r;
	logic [pix_bits-1:0] rdata_b;
	logic done;

	logic [pix_bits-1:0] mem_g [num_pix];
	logic [pix_bits-1:0] mem_r [num_pix];
	logic [pix_bits-1:0] mem_b [num_pix];
	logic [pix_bits-1:0] raw_img [num_pix];
	logic [31:0] rng_state;
	int exp_addr_q [$];
	rgb_t exp_rgb_q [$];

	`include "tb_demosaic_model.svh"

	demosaic_top dut (
		.clk(clk),
		.reset(reset),
		.in_en_i(in_en),
		.data_in_i(data_in),
		.wr_g_o(wr_g),
		.wr_r_o(wr_r),
		.wr_b_o(wr_b),
		.addr_g_o(addr_g),
		.addr_r_o(addr_r),
		.addr_b_o(addr_b),
		.wdata_g_o(wdata_g),
		.wdata_r_o(wdata_r),
		.wdata_b_o(wdata_b),
		.rdata_g_i(rdata_g),
		.rdata_r_i(rdata_r),
		.rdata_b_i(rdata_b),
		.done_o(done)
	);

	// ----------------------------------------
	// colour memories, async read
	// ----------------------------------------
	assign rdata_g = mem_g[addr_g];
	assign rdata_r = mem_r[addr_r];
	assign rdata_b = mem_b[addr_b];

	always @(posedge clk) begin
		if (wr_g) begin
			mem_g[addr_g] <= wdata_g;
		end
		if (wr_r) begin
			mem_r[addr_r] <= wdata_r;
		end
		if (wr_b) begin
			mem_b[addr_b] <= wdata_b;
		end
	end

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic abort_run(input string reason);
		$display("ERROR at %0t: %s", $time, reason);
		$display("Testbench failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// P lines patch the raw image, E lines queue an expected triple
	task automatic load_vectors();
		int fd;
		int n;
		int y;
		int x;
		int v;
		int g;
		int r;
		int b;
		string line;
		rgb_t t;
		fd = $fopen("demosaic_top_vectors.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open demosaic_top_vectors.txt");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.substr(0, 0) == "P") begin
				n = $sscanf(line, "P %h %h %h", y, x, v);
				if (n != 3) begin
					abort_run("malformed P line in the vector file");
				end
				raw_img[y * img_dim + x] = v[pix_bits-1:0];
			end else if (n > 0 && line.substr(0, 0) == "E") begin
				n = $sscanf(line, "E %h %h %h %h %h", y, x, g, r, b);
				if (n != 5) begin
					abort_run("malformed E line in the vector file");
				end
				t.g = g[pix_bits-1:0];
				t.r = r[pix_bits-1:0];
				t.b = b[pix_bits-1:0];
				exp_addr_q.push_back(y * img_dim + x);
				exp_rgb_q.push_back(t);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int cycles;
		int fill_addr;
		int a;
		reset = 1'b1;
		in_en = 1'b0;
		data_in = '0;
		rng_state = 32'd76023;
		for (a = 0; a < num_pix; a++) begin
			rng_state = xorshift32(rng_state);
			raw_img[a] = rng_state[pix_bits-1:0];
		end
		load_vectors();
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;

		// idle after reset
		repeat (4) begin
			@(negedge clk);
			check_value("done_o", done, 1'b0);
			check_value("wr_g_o wr_r_o wr_b_o", {wr_g, wr_r, wr_b}, 3'b000);
		end

		// ----------------------------------------
		// fill, with random idle cycles
		// ----------------------------------------
		fill_addr = 0;
		cycles = 0;
		while (fill_addr < num_pix) begin
			@(posedge clk);
			#1;
			rng_state = xorshift32(rng_state);
			in_en = (rng_state[3:0] != 4'd0);
			data_in = raw_img[fill_addr];
			@(negedge clk);
			if (in_en) begin
				check_value("wr_g_o wr_r_o wr_b_o", {wr_g, wr_r, wr_b}, 3'b111);
				check_value("addr_g_o", addr_g, fill_addr);
				check_value("addr_r_o", addr_r, fill_addr);
				check_value("addr_b_o", addr_b, fill_addr);
				check_value("wdata_g_o", wdata_g, raw_img[fill_addr]);
				check_value("wdata_r_o", wdata_r, raw_img[fill_addr]);
				check_value("wdata_b_o", wdata_b, raw_img[fill_addr]);
				fill_addr++;
			end else begin
				check_value("wr_g_o wr_r_o wr_b_o", {wr_g, wr_r, wr_b}, 3'b000);
			end
			cycles++;
			if (cycles > fill_timeout) begin
				abort_run("fill did not finish in time");
			end
		end
		@(posedge clk);
		#1 in_en = 1'b0;

		cycles = 0;
		while (done !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > done_timeout) begin
				abort_run("done_o did not rise after the fill");
			end
		end
		repeat (20) begin
			@(negedge clk);
			check_value("done_o", done, 1'b1);
		end

		// ----------------------------------------
		// memory contents
		// ----------------------------------------
		foreach (exp_addr_q[i]) begin
			a = exp_addr_q[i];
			check_value($sformatf("vector rgb at y %0d x %0d", a / img_dim, a % img_dim),
				{mem_g[a], mem_r[a], mem_b[a]}, exp_rgb_q[i]);
		end
		for (a = 0; a < num_pix; a++) begin
			check_value($sformatf("rgb at y %0d x %0d", a / img_dim, a % img_dim),
				{mem_g[a], mem_r[a], mem_b[a]}, expected_rgb(a / img_dim, a % img_dim));
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- demosaic_top_vectors.txt
# P y x raw overrides one raw sample, all fields hex
# E y x g r b is the expected triple after done, all fields hex
P 00 00 40
P 00 01 81
P 01 00 20
E 00 00 40 81 20
P 7f 7f 11
P 7e 7f fe
P 7f 7e 03
E 7f 7f 11 fe 03
P 21 21 55
P 20 21 10
P 22 21 13
P 21 20 ff
P 21 22 00
E 21 21 55 12 80
P 00 7f c8
P 01 7f 01
P 00 7e 02
P 01 7e 9a
E 00 7f 02 c8 9a
P 7f 00 77
P 7e 00 30
P 7f 01 31
P 7e 01 e5
E 7f 00 31 e5 77
P 40 00 a0
P 40 01 0f
P 3f 00 64
P 41 00 65
E 40 00 a0 0f 65

//--- demosaic_top.f
+incdir+.
demosaic_pkg.sv
demosaic_ctrl.sv
neighbor_fetch.sv
bilinear_interp.sv
mem_port_arb.sv
demosaic_top.sv
tb_demosaic_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the demosaic testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f demosaic_top.f --top-module tb_demosaic_top -o tb_demosaic_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_demosaic_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
